// File: verification/pc_unit_input.txt
// rst instr rs1 rs2 stall trap_valid trap_pc exp_pc exp_link, all hex
// one cycle per line, expected pc_o and link_o sampled after the rising edge
0 00100093 00000000 00000000 0 0 00000000 80000004 80000008 // addi steps
0 00100093 00000000 00000000 0 0 00000000 80000008 8000000c
0 00100093 00000000 00000000 0 0 00000000 8000000c 80000010
0 00208863 00000005 00000005 0 0 00000000 8000001c 80000020 // beq taken
0 00208863 00000005 00000006 0 0 00000000 80000020 80000024 // beq not taken
0 00209863 00000001 00000002 0 0 00000000 80000030 80000034 // bne taken
0 00209863 00000007 00000007 0 0 00000000 80000034 80000038 // bne not taken
0 0020c863 ffffffff 00000001 0 0 00000000 80000044 80000048 // blt -1 < 1
0 0020c863 00000001 ffffffff 0 0 00000000 80000048 8000004c // blt 1 < -1 false
0 0020d863 00000001 ffffffff 0 0 00000000 80000058 8000005c // bge taken
0 0020d863 80000000 00000000 0 0 00000000 8000005c 80000060 // bge min int
0 0020d863 fffffff0 fffffff0 0 0 00000000 8000006c 80000070 // bge equal
0 0020e863 00000001 ffffffff 0 0 00000000 8000007c 80000080 // bltu taken
0 0020e863 ffffffff 00000001 0 0 00000000 80000080 80000084 // bltu not taken
0 0020f863 ffffffff 00000001 0 0 00000000 80000090 80000094 // bgeu taken
0 0020f863 00000000 80000000 0 0 00000000 80000094 80000098 // bgeu not taken
0 fe209ce3 00000003 00000004 0 0 00000000 8000008c 80000090 // bne -8 taken
0 fe209ce3 00000004 00000004 0 0 00000000 80000090 80000094 // bne -8 not taken
0 0020a863 00000005 00000005 0 0 00000000 80000094 80000098 // funct3 010 never taken
0 100000ef 00000000 00000000 0 0 00000000 80000194 80000198 // jal +256
0 005100e7 80001000 00000000 0 0 00000000 80001004 80001008 // jalr +5, bit 0 cleared
0 ffd100e7 80002000 00000000 0 0 00000000 80001ffc 80002000 // jalr -3
0 ff1ff0ef 00000000 00000000 0 0 00000000 80001fec 80001ff0 // jal -16
0 00000000 00000000 00000000 0 0 00000000 80001fec 80001ff0 // bubble holds
0 00000000 00000000 00000000 0 0 00000000 80001fec 80001ff0
0 00100093 00000000 00000000 1 0 00000000 80001fec 80001ff0 // stall holds
0 100000ef 00000000 00000000 1 0 00000000 80001fec 80001ff0 // stalled jal
0 00100093 00000000 00000000 1 1 80000200 80001fec 80001ff0 // trap lost in stall
0 00100093 00000000 00000000 0 0 00000000 80001ff0 80001ff4
0 00100093 00000000 00000000 0 1 80000200 80000200 80000204 // trap
0 00208863 00000005 00000005 0 1 80000300 80000300 80000304 // trap over taken beq
0 100000ef 00000000 00000000 0 1 80000400 80000400 80000404 // trap over jal
0 00000000 00000000 00000000 0 1 80000500 80000500 80000504 // trap over bubble
0 00100093 00000000 00000000 0 0 00000000 80000504 80000508
1 00100093 00000000 00000000 0 0 00000000 80000000 80000004 // reset mid run
0 00100093 00000000 00000000 0 0 00000000 80000004 80000008
0 ff1ff0ef 00000000 00000000 0 0 00000000 7ffffff4 7ffffff8 // jal -16 below reset addr
0 00100093 00000000 00000000 0 0 00000000 7ffffff8 7ffffffc

// File: flist.f
src/rv_pc_pkg.sv
src/pc_ctrl_if.sv
src/pc_decode.sv
src/branch_cmp.sv
src/pc_reg.sv
src/pc_unit_top.sv
verification/tb_clk_gen.sv
verification/pc_unit_tb.sv

// File: verification/pc_unit_tb.sv
`timescale 1ns/10ps

module pc_unit_tb;

  // vector table layout with one row of columns per cycle
  localparam int NUM_COLS    = 9;
  localparam int MAX_VECTORS = 64;
  localparam int MEM_WORDS   = NUM_COLS * MAX_VECTORS;
  localparam int COL_RST     = 0;
  localparam int COL_INSTR   = 1;
  localparam int COL_RS1     = 2;
  localparam int COL_RS2     = 3;
  localparam int COL_STALL   = 4;
  localparam int COL_TRAP    = 5;
  localparam int COL_TRAP_PC = 6;
  localparam int COL_EXP_PC  = 7;
  localparam int COL_EXP_LNK = 8;
  // inputs change this long after the rising edge
  localparam real DRIVE_DELAY  = 1.0;
  // half-ns polls give 20 ns without an edge
  localparam int EDGE_TIMEOUT  = 40;
  localparam int RESET_CYCLES  = 8;

  logic                       clk;
  logic                       rst_i;
  logic [31:0]                instr_i;
  logic [rv_pc_pkg::XLEN-1:0] rs1_data_i;
  logic [rv_pc_pkg::XLEN-1:0] rs2_data_i;
  logic                       stall_i;
  logic                       trap_valid_i;
  logic [rv_pc_pkg::XLEN-1:0] trap_pc_i;
  logic [rv_pc_pkg::XLEN-1:0] pc_o;
  logic [rv_pc_pkg::XLEN-1:0] link_o;

  // raw words from the data file
  logic [31:0] vec_mem [MEM_WORDS];
  int          num_vectors;
  int          vectors_run;

  // edge bookkeeping for the polled waits
  int      edge_count = 0;
  realtime last_edge_time = 0.0;

  int pc_errors;
  int link_errors;
  int other_errors;

  tb_clk_gen u_clk_gen (
    .clk_o (clk)
  );

  pc_unit_top pc_unit_top_inst (
    .clk          (clk),
    .rst_i        (rst_i),
    .instr_i      (instr_i),
    .rs1_data_i   (rs1_data_i),
    .rs2_data_i   (rs2_data_i),
    .stall_i      (stall_i),
    .trap_valid_i (trap_valid_i),
    .trap_pc_i    (trap_pc_i),
    .pc_o         (pc_o),
    .link_o       (link_o)
  );

  always @(posedge clk) begin
    edge_count     <= edge_count + 1;
    last_edge_time <= $realtime;
  end

  // marks words the file never wrote
  function automatic logic [31:0] fill_word(input int addr);
    return 32'hfeed_0000 ^ addr;
  endfunction

  task automatic load_vectors(output bit ok);
    int addr;
    int v;
    int c;
    int missing;
    int last_base;
    for (addr = 0; addr < MEM_WORDS; addr++) begin
      vec_mem[addr] = fill_word(addr);
    end
    $readmemh("verification/pc_unit_input.txt", vec_mem);
    ok = 1'b1;
    num_vectors = 0;
    // a row counts once its rst column was written
    while (num_vectors < MAX_VECTORS &&
           vec_mem[num_vectors * NUM_COLS] !== fill_word(num_vectors * NUM_COLS)) begin
      num_vectors++;
    end
    if (num_vectors == 0) begin
      $display("Error: data file verification/pc_unit_input.txt is missing or has no vectors");
      other_errors++;
      ok = 1'b0;
      return;
    end
    // truncated last row
    missing = 0;
    last_base = (num_vectors - 1) * NUM_COLS;
    for (c = 0; c < NUM_COLS; c++) begin
      if (vec_mem[last_base + c] === fill_word(last_base + c)) begin
        missing++;
      end
    end
    if (missing != 0) begin
      $display("Error: data file ends partway through vector %0d", num_vectors - 1);
      other_errors++;
      ok = 1'b0;
      return;
    end
    // flag columns hold 0 or 1 unless the columns shifted
    for (v = 0; v < num_vectors; v++) begin
      if (vec_mem[v * NUM_COLS + COL_RST] > 1 || vec_mem[v * NUM_COLS + COL_STALL] > 1 ||
          vec_mem[v * NUM_COLS + COL_TRAP] > 1) begin
        $display("Error: vector %0d has a flag column that is not 0 or 1", v);
        other_errors++;
        ok = 1'b0;
      end
    end
  endtask

  // returns DRIVE_DELAY after the next rising edge
  task automatic wait_edge(output bit ok);
    int start_count;
    int polls;
    start_count = edge_count;
    polls = 0;
    while (edge_count == start_count && polls < EDGE_TIMEOUT) begin
      #0.5;
      polls++;
    end
    if (edge_count == start_count) begin
      $display("Error: timed out waiting for a rising clock edge at %0t", $realtime);
      other_errors++;
      ok = 1'b0;
    end else begin
      ok = 1'b1;
      // poll may see the edge late by half a ns
      #(last_edge_time + DRIVE_DELAY - $realtime);
    end
  endtask

  task automatic check_pc(input logic [rv_pc_pkg::XLEN-1:0] expected, input string where);
    if (pc_o !== expected) begin
      pc_errors++;
      $display("Fail pc_o %s: expected %h, got %h", where, expected, pc_o);
    end
  endtask

  task automatic check_link(input logic [rv_pc_pkg::XLEN-1:0] expected, input string where);
    if (link_o !== expected) begin
      link_errors++;
      $display("Fail link_o %s: expected %h, got %h", where, expected, link_o);
    end
  endtask

  task automatic drive_vector(input int v);
    int base;
    base = v * NUM_COLS;
    rst_i        = vec_mem[base + COL_RST][0];
    instr_i      = vec_mem[base + COL_INSTR];
    rs1_data_i   = vec_mem[base + COL_RS1];
    rs2_data_i   = vec_mem[base + COL_RS2];
    stall_i      = vec_mem[base + COL_STALL][0];
    trap_valid_i = vec_mem[base + COL_TRAP][0];
    trap_pc_i    = vec_mem[base + COL_TRAP_PC];
  endtask

  task automatic run_reset(output bit ok);
    int  cyc;
    bit  edge_ok;
    logic [rv_pc_pkg::XLEN-1:0] reset_link;
    ok = 1'b1;
    rst_i = 1'b1;
    for (cyc = 0; cyc < RESET_CYCLES; cyc++) begin
      wait_edge(edge_ok);
      if (!edge_ok) begin
        ok = 1'b0;
        return;
      end
    end
    rst_i = 1'b0;
    // link is the word after the first fetch address
    reset_link = rv_pc_pkg::PC_RESET_ADDR + 32'd4;
    check_pc(rv_pc_pkg::PC_RESET_ADDR, "after reset");
    check_link(reset_link, "after reset");
  endtask

  task automatic run_vectors(output bit ok);
    int    v;
    int    base;
    bit    edge_ok;
    string where;
    ok = 1'b1;
    for (v = 0; v < num_vectors; v++) begin
      base = v * NUM_COLS;
      drive_vector(v);
      wait_edge(edge_ok);
      if (!edge_ok) begin
        ok = 1'b0;
        return;
      end
      // pc_o settled at the edge and link follows it
      where = $sformatf("vector %0d", v);
      check_pc(vec_mem[base + COL_EXP_PC], where);
      check_link(vec_mem[base + COL_EXP_LNK], where);
      vectors_run++;
    end
  endtask

  task automatic finish_run();
    int total;
    total = pc_errors + link_errors + other_errors;
    $display("errors: pc_o %0d, link_o %0d, other %0d, over %0d vectors",
             pc_errors, link_errors, other_errors, vectors_run);
    if (total == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  initial begin
    bit ok;
    rst_i        = 1'b1;
    instr_i      = rv_pc_pkg::INSTR_BUBBLE;
    rs1_data_i   = '0;
    rs2_data_i   = '0;
    stall_i      = 1'b0;
    trap_valid_i = 1'b0;
    trap_pc_i    = '0;
    pc_errors    = 0;
    link_errors  = 0;
    other_errors = 0;
    vectors_run  = 0;
    load_vectors(ok);
    if (ok) begin
      run_reset(ok);
    end
    if (ok) begin
      run_vectors(ok);
    end
    finish_run();
  end

endmodule

// File: verification/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_o
);

  // half of the 8 ns period
  localparam real HALF_PERIOD = 4.0;

  // starts low, first rising edge at 4 ns
  initial begin
    clk_o = 1'b0;
    forever begin
      #(HALF_PERIOD);
      clk_o = ~clk_o;
    end
  end

endmodule

// File: src/pc_unit_top.sv
`timescale 1ns/10ps

module pc_unit_top (
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic [31:0]                instr_i,
  input  logic [rv_pc_pkg::XLEN-1:0] rs1_data_i,
  input  logic [rv_pc_pkg::XLEN-1:0] rs2_data_i,
  input  logic                       stall_i,
  input  logic                       trap_valid_i,
  input  logic [rv_pc_pkg::XLEN-1:0] trap_pc_i,
  output logic [rv_pc_pkg::XLEN-1:0] pc_o,
  output logic [rv_pc_pkg::XLEN-1:0] link_o
);

  // raw fetch word reinterpreted as format views
  rv_pc_pkg::rv_instr_u instr_u;

  assign instr_u = rv_pc_pkg::rv_instr_u'(instr_i);

  // decoded control, decode -> cmp -> pc register
  pc_ctrl_if pc_ctrl ();

  // opcode class, immediate, funct3
  pc_decode u_pc_decode (
    .instr_i (instr_u),
    .ctrl    (pc_ctrl.dec)
  );

  // branch condition from register operands
  branch_cmp u_branch_cmp (
    .rs1_data_i (rs1_data_i),
    .rs2_data_i (rs2_data_i),
    .ctrl       (pc_ctrl.cmp)
  );

  // next-pc select and pc state
  pc_reg u_pc_reg (
    .clk          (clk),
    .rst_i        (rst_i),
    .stall_i      (stall_i),
    .trap_valid_i (trap_valid_i),
    .trap_pc_i    (trap_pc_i),
    .rs1_data_i   (rs1_data_i),
    .ctrl         (pc_ctrl.consumer),
    .pc_o         (pc_o),
    .link_o       (link_o)
  );

endmodule

// File: src/pc_reg.sv
`timescale 1ns/10ps

module pc_reg (
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic                       stall_i,
  input  logic                       trap_valid_i,
  input  logic [rv_pc_pkg::XLEN-1:0] trap_pc_i,
  input  logic [rv_pc_pkg::XLEN-1:0] rs1_data_i,
  pc_ctrl_if.consumer                ctrl,
  output logic [rv_pc_pkg::XLEN-1:0] pc_o,
  output logic [rv_pc_pkg::XLEN-1:0] link_o
);

  // one-hot view of the operation
  logic op_none;
  logic op_inc4;
  logic op_branch;
  logic op_jal;
  logic op_jalr;
  // branch resolved either way
  logic br_taken;
  logic seq_step;
  // pc based target, any of branch/jal/step/hold
  logic use_pc;
  // imm as second operand
  logic use_imm;

  logic [rv_pc_pkg::XLEN-1:0] pc_q;
  logic [rv_pc_pkg::XLEN-1:0] add_a;
  logic [rv_pc_pkg::XLEN-1:0] add_b;
  logic [rv_pc_pkg::XLEN-1:0] add_sum;
  logic [rv_pc_pkg::XLEN-1:0] pc_normal;
  logic [rv_pc_pkg::XLEN-1:0] pc_next;
  logic                       pc_wen;

  assign op_none   = (ctrl.pc_op == rv_pc_pkg::PCOP_NONE);
  assign op_inc4   = (ctrl.pc_op == rv_pc_pkg::PCOP_INC4);
  assign op_branch = (ctrl.pc_op == rv_pc_pkg::PCOP_BRANCH);
  assign op_jal    = (ctrl.pc_op == rv_pc_pkg::PCOP_JAL);
  assign op_jalr   = (ctrl.pc_op == rv_pc_pkg::PCOP_JALR);

  // not-taken branch falls back to +4
  assign br_taken = op_branch & ctrl.taken;
  assign seq_step = op_inc4 | (op_branch & ~ctrl.taken);

  assign use_pc  = br_taken | op_jal | seq_step | op_none;
  assign use_imm = br_taken | op_jal | op_jalr;

  // and-or operand mux
  // bubble adds zero to pc, so it holds
  assign add_a = ({rv_pc_pkg::XLEN{use_pc}} & pc_q) |
                 ({rv_pc_pkg::XLEN{op_jalr}} & rs1_data_i);
  assign add_b = ({rv_pc_pkg::XLEN{use_imm}} & ctrl.imm) |
                 ({rv_pc_pkg::XLEN{seq_step}} & {{(rv_pc_pkg::XLEN-3){1'b0}}, 3'd4});

  // single target adder
  assign add_sum = add_a + add_b;

  // jalr target is halfword aligned per spec
  assign pc_normal = {add_sum[rv_pc_pkg::XLEN-1:1], add_sum[0] & ~op_jalr};

  // trap wins over any control flow
  assign pc_next = trap_valid_i ? trap_pc_i : pc_normal;

  // stall freezes pc, a trap during stall is lost
  assign pc_wen = ~stall_i;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc_q <= rv_pc_pkg::PC_RESET_ADDR;
    end else if (pc_wen) begin
      pc_q <= pc_next;
    end
  end

  assign pc_o = pc_q;

  // return address for jal/jalr writeback
  assign link_o = pc_q + {{(rv_pc_pkg::XLEN-3){1'b0}}, 3'd4};

endmodule

// File: src/branch_cmp.sv
`timescale 1ns/10ps

module branch_cmp (
  input  logic [rv_pc_pkg::XLEN-1:0] rs1_data_i,
  input  logic [rv_pc_pkg::XLEN-1:0] rs2_data_i,
  pc_ctrl_if.cmp                     ctrl
);

  // shared relations, one compare each
  logic is_eq;
  logic is_lt_s;
  logic is_lt_u;

  assign is_eq   = (rs1_data_i == rs2_data_i);
  // two's complement order
  assign is_lt_s = ($signed(rs1_data_i) < $signed(rs2_data_i));
  assign is_lt_u = (rs1_data_i < rs2_data_i);

  // pick relation by funct3
  // ge forms are the inverse of lt
  always_comb begin
    case (ctrl.funct3)
      rv_pc_pkg::F3_BEQ:  ctrl.taken = is_eq;
      rv_pc_pkg::F3_BNE:  ctrl.taken = ~is_eq;
      rv_pc_pkg::F3_BLT:  ctrl.taken = is_lt_s;
      rv_pc_pkg::F3_BGE:  ctrl.taken = ~is_lt_s;
      rv_pc_pkg::F3_BLTU: ctrl.taken = is_lt_u;
      rv_pc_pkg::F3_BGEU: ctrl.taken = ~is_lt_u;
      // reserved codes 010, 011 never branch
      default:            ctrl.taken = 1'b0;
    endcase
  end

endmodule

// File: src/pc_decode.sv
`timescale 1ns/10ps

module pc_decode (
  input  rv_pc_pkg::rv_instr_u instr_i,
  pc_ctrl_if.dec               ctrl
);

  // major opcode, same bits in every view
  logic [6:0]                 opcode;
  // empty slot flag
  logic                       is_bubble;
  // candidate immediates, one per format
  logic [rv_pc_pkg::XLEN-1:0] imm_b;
  logic [rv_pc_pkg::XLEN-1:0] imm_j;
  logic [rv_pc_pkg::XLEN-1:0] imm_i;
  // decoded operation, local copy
  rv_pc_pkg::pc_op_e          pc_op;

  assign opcode    = instr_i.i_fmt.opcode;
  assign is_bubble = (instr_i == rv_pc_pkg::INSTR_BUBBLE);

  // b-type offset, even, +-4 KiB
  assign imm_b = {
    {19{instr_i.b_fmt.imm12}},
    instr_i.b_fmt.imm12,
    instr_i.b_fmt.imm11,
    instr_i.b_fmt.imm10_5,
    instr_i.b_fmt.imm4_1,
    1'b0
  };

  // j-type offset, even, +-1 MiB
  assign imm_j = {
    {11{instr_i.j_fmt.imm20}},
    instr_i.j_fmt.imm20,
    instr_i.j_fmt.imm19_12,
    instr_i.j_fmt.imm11,
    instr_i.j_fmt.imm10_1,
    1'b0
  };

  // i-type offset, 12 bit signed
  assign imm_i = {
    {20{instr_i.i_fmt.imm11_0[11]}},
    instr_i.i_fmt.imm11_0
  };

  // operation class from opcode
  always_comb begin
    if (is_bubble) begin
      pc_op = rv_pc_pkg::PCOP_NONE;
    end else begin
      case (opcode)
        rv_pc_pkg::OPC_BRANCH: pc_op = rv_pc_pkg::PCOP_BRANCH;
        rv_pc_pkg::OPC_JAL:    pc_op = rv_pc_pkg::PCOP_JAL;
        rv_pc_pkg::OPC_JALR:   pc_op = rv_pc_pkg::PCOP_JALR;
        // alu, load, store etc just step
        default:               pc_op = rv_pc_pkg::PCOP_INC4;
      endcase
    end
  end

  // immediate follows the operation
  always_comb begin
    case (pc_op)
      rv_pc_pkg::PCOP_BRANCH: ctrl.imm = imm_b;
      rv_pc_pkg::PCOP_JAL:    ctrl.imm = imm_j;
      rv_pc_pkg::PCOP_JALR:   ctrl.imm = imm_i;
      // no offset for sequential or bubble
      default:                ctrl.imm = '0;
    endcase
  end

  assign ctrl.pc_op = pc_op;

  // condition code straight through to comparator
  // meaningful only for branches
  assign ctrl.funct3 = instr_i.b_fmt.funct3;

endmodule

// File: src/pc_ctrl_if.sv
`timescale 1ns/10ps

interface pc_ctrl_if;

  // next-pc operation class
  rv_pc_pkg::pc_op_e           pc_op;
  // sign-extended target offset
  logic [rv_pc_pkg::XLEN-1:0]  imm;
  // branch condition select
  logic [2:0]                  funct3;
  // branch condition result
  logic                        taken;

  // decode side
  modport dec (output pc_op, output imm, output funct3);

  // comparator reads the condition code, returns the outcome
  modport cmp (input funct3, output taken);

  // pc register side
  modport consumer (input pc_op, input imm, input taken);

endinterface

// File: src/rv_pc_pkg.sv
package rv_pc_pkg;

  // datapath and address width
  localparam int XLEN = 32;

  // first fetch address after reset
  localparam logic [XLEN-1:0] PC_RESET_ADDR = 32'h8000_0000;

  // next-pc operation, chosen by decode
  typedef enum logic [2:0] {
    // hold pc, bubble
    PCOP_NONE   = 3'd0,
    // sequential, pc + 4
    PCOP_INC4   = 3'd1,
    // conditional, pc + imm when taken
    PCOP_BRANCH = 3'd2,
    // pc + imm
    PCOP_JAL    = 3'd3,
    // rs1 + imm, bit 0 cleared
    PCOP_JALR   = 3'd4
  } pc_op_e;

  // b-type view, conditional branches
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  // j-type view, jal
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // i-type view, jalr
  typedef struct packed {
    logic [11:0] imm11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // one instruction word, three decodings
  typedef union packed {
    b_fmt_t b_fmt;
    j_fmt_t j_fmt;
    i_fmt_t i_fmt;
  } rv_instr_u;

  // control-flow major opcodes
  localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
  localparam logic [6:0] OPC_JAL    = 7'b110_1111;
  localparam logic [6:0] OPC_JALR   = 7'b110_0111;

  // branch funct3 codes
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // empty fetch slot
  localparam logic [31:0] INSTR_BUBBLE = 32'h0000_0000;

endpackage
